// ==== hdl/arm_settings.svh ====
`ifndef ARM_SETTINGS_SVH
`define ARM_SETTINGS_SVH

// ============================================================
// Register file shape.
// ============================================================
`define ARM_NREGS 16
// The PC is never tracked as a dependency.
`define ARM_PC_IDX 15

// ============================================================
// CPSR flag bit positions.
// ============================================================
`define CPSR_N 31
`define CPSR_Z 30
`define CPSR_C 29
`define CPSR_V 28

// Execute and memory stages hold pending writes.
`define ISSUE_INFLIGHT 2

`endif

// ==== hdl/arm_pkg.sv ====
`include "arm_settings.svh"

package arm_pkg;

	// Instruction, PC and CPSR words.
	typedef logic [31:0] word_t;

	// One bit per architectural register.
	typedef logic [`ARM_NREGS-1:0] reg_mask_t;

	// Encoding classes, in decode priority order.
	typedef enum logic [4:0]
	{
		cls_multiply,
		cls_mrs,
		cls_msr,
		cls_msr_flags,
		cls_swap,
		cls_bx,
		cls_half_reg,
		cls_half_imm,
		cls_alu,
		cls_undefined,
		cls_ldr_str,
		cls_ldm_stm,
		cls_branch,
		cls_cop_xfer,
		cls_cop_data,
		cls_cop_reg,
		cls_none
	} insn_class_e;

	// Data processing opcodes, insn[24:21].
	typedef enum logic [3:0]
	{
		alu_and, alu_eor, alu_sub, alu_rsb,
		alu_add, alu_adc, alu_sbc, alu_rsc,
		alu_tst, alu_teq, alu_cmp, alu_cmn,
		alu_orr, alu_mov, alu_bic, alu_mvn
	} alu_op_e;

	// Condition field, insn[31:28].
	typedef enum logic [3:0]
	{
		cond_eq, cond_ne, cond_cs, cond_cc,
		cond_mi, cond_pl, cond_vs, cond_vc,
		cond_hi, cond_ls, cond_ge, cond_lt,
		cond_gt, cond_le, cond_al, cond_nv
	} cond_e;

	// Shifter type, insn[6:5].
	typedef enum logic [1:0]
	{
		shift_lsl,
		shift_lsr,
		shift_asr,
		shift_ror
	} shift_e;

endpackage

// ==== hdl/dep_if.sv ====
// Read and write sets of the instruction sitting at issue.
interface dep_if;

	logic use_cpsr;
	arm_pkg::reg_mask_t use_regs;
	logic def_cpsr;
	arm_pkg::reg_mask_t def_regs;

	modport decoder
	(
		output use_cpsr, use_regs, def_cpsr, def_regs
	);

	modport issue
	(
		input use_cpsr, use_regs, def_cpsr, def_regs
	);

endinterface

// ==== hdl/dep_decoder.sv ====
`include "arm_settings.svh"

module dep_decoder
(
	input arm_pkg::word_t insn,
	dep_if.decoder deps
);

	localparam arm_pkg::reg_mask_t pc_mask = arm_pkg::reg_mask_t'(1) << `ARM_PC_IDX;

	arm_pkg::insn_class_e cls;
	arm_pkg::alu_op_e op;
	arm_pkg::cond_e cond;
	arm_pkg::shift_e sh_type;
	logic cond_used;
	logic load;
	logic flags_only;
	logic shift_carry;
	arm_pkg::reg_mask_t reg_list;

	// Register number to set bit; the PC maps to the empty set.
	function automatic arm_pkg::reg_mask_t reg_bit(input logic [3:0] r);
		arm_pkg::reg_mask_t m;
		m = '0;
		if (r != 4'(`ARM_PC_IDX))
			m[r] = 1'b1;
		return m;
	endfunction

	assign op = arm_pkg::alu_op_e'(insn[24:21]);
	assign cond = arm_pkg::cond_e'(insn[31:28]);
	assign sh_type = arm_pkg::shift_e'(insn[6:5]);
	assign cond_used = (cond != arm_pkg::cond_al);
	assign load = insn[20];
	assign reg_list = insn[`ARM_NREGS-1:0] & ~pc_mask;
	assign flags_only = op inside {arm_pkg::alu_tst, arm_pkg::alu_teq,
		arm_pkg::alu_cmp, arm_pkg::alu_cmn};

	// LSL #0 passes the carry through, ROR #0 is RRX.
	assign shift_carry = !insn[25] && !insn[4] && (insn[11:7] == 5'd0) &&
		(sh_type == arm_pkg::shift_lsl || sh_type == arm_pkg::shift_ror);

	// ============================================================
	// Encoding match. Multiply sits inside the ALU space.
	// ============================================================
	always_comb
	begin
		if (insn[27:22] == 6'b000000 && insn[7:4] == 4'b1001)
			cls = arm_pkg::cls_multiply;
		else if (insn[27:23] == 5'b00010 && insn[21:16] == 6'b001111 && insn[11:0] == 12'h000)
			cls = arm_pkg::cls_mrs;
		else if (insn[27:23] == 5'b00010 && insn[21:4] == 18'b10_1001_1111_0000_0000)
			cls = arm_pkg::cls_msr;
		else if (insn[27:26] == 2'b00 && insn[24:23] == 2'b10 && insn[21:12] == 10'b10_1000_1111)
			cls = arm_pkg::cls_msr_flags;
		else if (insn[27:23] == 5'b00010 && insn[21:20] == 2'b00 && insn[11:4] == 8'h09)
			cls = arm_pkg::cls_swap;
		else if (insn[27:4] == 24'h12_fff1)
			cls = arm_pkg::cls_bx;
		else if (insn[27:25] == 3'b000 && !insn[22] && insn[11:7] == 5'b00001 && insn[4])
			cls = arm_pkg::cls_half_reg;
		else if (insn[27:25] == 3'b000 && insn[22] && insn[7] && insn[4])
			cls = arm_pkg::cls_half_imm;
		else if (insn[27:26] == 2'b00)
			cls = arm_pkg::cls_alu;
		else if (insn[27:25] == 3'b011 && insn[4])
			cls = arm_pkg::cls_undefined;
		else if (insn[27:26] == 2'b01)
			cls = arm_pkg::cls_ldr_str;
		else if (insn[27:25] == 3'b100)
			cls = arm_pkg::cls_ldm_stm;
		else if (insn[27:25] == 3'b101)
			cls = arm_pkg::cls_branch;
		else if (insn[27:25] == 3'b110)
			cls = arm_pkg::cls_cop_xfer;
		else if (insn[27:24] == 4'b1110 && !insn[4])
			cls = arm_pkg::cls_cop_data;
		else if (insn[27:24] == 4'b1110)
			cls = arm_pkg::cls_cop_reg;
		else
			cls = arm_pkg::cls_none;
	end

	// ============================================================
	// Use and define sets per class.
	// ============================================================
	always_comb
	begin
		deps.use_cpsr = cond_used;
		deps.use_regs = '0;
		deps.def_cpsr = 1'b0;
		deps.def_regs = '0;
		case (cls)
			arm_pkg::cls_multiply:
			begin
				deps.use_regs = (insn[21] ? reg_bit(insn[15:12]) : '0) |
					reg_bit(insn[11:8]) | reg_bit(insn[3:0]);
				deps.def_cpsr = insn[20];
				deps.def_regs = reg_bit(insn[19:16]);
			end
			arm_pkg::cls_mrs:
			begin
				// Reading the CPSR itself, not the SPSR.
				deps.use_cpsr = cond_used || !insn[22];
				deps.def_regs = reg_bit(insn[15:12]);
			end
			arm_pkg::cls_msr, arm_pkg::cls_msr_flags:
			begin
				deps.use_regs = (cls == arm_pkg::cls_msr_flags && insn[25]) ? '0 :
					reg_bit(insn[3:0]);
				deps.def_cpsr = 1'b1;
			end
			arm_pkg::cls_swap:
			begin
				deps.use_regs = reg_bit(insn[19:16]) | reg_bit(insn[3:0]);
				deps.def_regs = reg_bit(insn[15:12]);
			end
			arm_pkg::cls_bx:
				deps.use_regs = reg_bit(insn[3:0]);
			arm_pkg::cls_half_reg, arm_pkg::cls_half_imm, arm_pkg::cls_ldr_str:
			begin
				deps.use_regs = reg_bit(insn[19:16]) | (load ? '0 : reg_bit(insn[15:12]));
				// Register offset forms also read Rm.
				if ((cls == arm_pkg::cls_half_reg) || (cls == arm_pkg::cls_ldr_str && insn[25]))
					deps.use_regs = deps.use_regs | reg_bit(insn[3:0]);
				deps.def_regs = load ? reg_bit(insn[15:12]) : '0;
			end
			arm_pkg::cls_alu:
			begin
				deps.use_cpsr = cond_used || shift_carry;
				if (!insn[25])
					deps.use_regs = reg_bit(insn[3:0]) | (insn[4] ? reg_bit(insn[11:8]) : '0);
				if (op != arm_pkg::alu_mov && op != arm_pkg::alu_mvn)
					deps.use_regs = deps.use_regs | reg_bit(insn[19:16]);
				deps.def_cpsr = insn[20];
				deps.def_regs = flags_only ? '0 : reg_bit(insn[15:12]);
			end
			arm_pkg::cls_ldm_stm:
			begin
				deps.use_regs = reg_bit(insn[19:16]) | (load ? '0 : reg_list);
				// S bit may restore the CPSR.
				deps.def_cpsr = insn[22];
				deps.def_regs = (insn[21] ? reg_bit(insn[19:16]) : '0) | (load ? reg_list : '0);
			end
			arm_pkg::cls_cop_xfer:
			begin
				deps.use_regs = reg_bit(insn[19:16]);
				deps.def_regs = insn[21] ? reg_bit(insn[19:16]) : '0;
			end
			arm_pkg::cls_cop_reg:
			begin
				deps.use_regs = load ? '0 : reg_bit(insn[15:12]);
				deps.def_regs = load ? reg_bit(insn[15:12]) : '0;
			end
			arm_pkg::cls_branch, arm_pkg::cls_cop_data:
				deps.use_regs = '0;
			default:
				// Undefined and unknown encodings carry no dependencies.
				deps.use_cpsr = 1'b0;
		endcase
	end

endmodule

// ==== hdl/cond_eval.sv ====
`include "arm_settings.svh"

module cond_eval
(
	input arm_pkg::word_t insn,
	input arm_pkg::word_t cpsr,
	output logic cond_met
);

	arm_pkg::cond_e cond;
	logic n;
	logic z;
	logic c;
	logic v;

	assign cond = arm_pkg::cond_e'(insn[31:28]);
	assign n = cpsr[`CPSR_N];
	assign z = cpsr[`CPSR_Z];
	assign c = cpsr[`CPSR_C];
	assign v = cpsr[`CPSR_V];

	// Standard ARM condition table.
	always_comb
	begin
		cond_met = 1'b0;
		case (cond)
			arm_pkg::cond_eq: cond_met = z;
			arm_pkg::cond_ne: cond_met = !z;
			arm_pkg::cond_cs: cond_met = c;
			arm_pkg::cond_cc: cond_met = !c;
			arm_pkg::cond_mi: cond_met = n;
			arm_pkg::cond_pl: cond_met = !n;
			arm_pkg::cond_vs: cond_met = v;
			arm_pkg::cond_vc: cond_met = !v;
			arm_pkg::cond_hi: cond_met = c && !z;
			arm_pkg::cond_ls: cond_met = !c || z;
			arm_pkg::cond_ge: cond_met = (n == v);
			arm_pkg::cond_lt: cond_met = (n != v);
			arm_pkg::cond_gt: cond_met = !z && (n == v);
			arm_pkg::cond_le: cond_met = z || (n != v);
			arm_pkg::cond_al: cond_met = 1'b1;
			// NV never executes.
			arm_pkg::cond_nv: cond_met = 1'b0;
		endcase
	end

endmodule

// ==== hdl/issue_ctl.sv ====
`include "arm_settings.svh"

module issue_ctl
(
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input logic inbubble,
	input arm_pkg::word_t insn,
	input arm_pkg::word_t inpc,
	dep_if.issue deps,
	input logic cond_met,
	output logic outstall,
	output logic outbubble,
	output arm_pkg::word_t outpc,
	output arm_pkg::word_t outinsn
);

	// Slot 0 is execute, the last slot is memory.
	logic cpsr_inflight [`ISSUE_INFLIGHT];
	arm_pkg::reg_mask_t regs_inflight [`ISSUE_INFLIGHT];

	logic pend_cpsr;
	arm_pkg::reg_mask_t pend_regs;
	logic waiting;
	logic kill;

	// Union of everything still to be written.
	always_comb
	begin
		pend_cpsr = 1'b0;
		pend_regs = '0;
		for (int i = 0; i < `ISSUE_INFLIGHT; i++)
		begin
			pend_cpsr = pend_cpsr | cpsr_inflight[i];
			pend_regs = pend_regs | regs_inflight[i];
		end
	end

	assign waiting = (deps.use_cpsr && pend_cpsr) || |(deps.use_regs & pend_regs);
	assign outstall = stall || (waiting && !inbubble);

	// Nothing issued from this slot reaches execute.
	assign kill = inbubble || waiting || !cond_met || flush;

	// ============================================================
	// Scoreboard shift and stage registers.
	// ============================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `ISSUE_INFLIGHT; i++)
			begin
				cpsr_inflight[i] <= 1'b0;
				regs_inflight[i] <= '0;
			end
			outbubble <= 1'b1;
			outpc <= '0;
			outinsn <= '0;
		end
		else if (!stall)
		begin
			for (int i = `ISSUE_INFLIGHT - 1; i > 0; i--)
			begin
				cpsr_inflight[i] <= cpsr_inflight[i-1];
				regs_inflight[i] <= regs_inflight[i-1];
			end
			cpsr_inflight[0] <= kill ? 1'b0 : deps.def_cpsr;
			regs_inflight[0] <= kill ? '0 : deps.def_regs;
			outbubble <= kill;
			outpc <= inpc;
			outinsn <= insn;
		end
	end

endmodule

// ==== hdl/issue_stage.sv ====
module issue_stage
(
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input logic inbubble,
	input arm_pkg::word_t insn,
	input arm_pkg::word_t inpc,
	input arm_pkg::word_t cpsr,
	output logic outstall,
	output logic outbubble,
	output arm_pkg::word_t outpc,
	output arm_pkg::word_t outinsn
);

	logic cond_met;

	// Decoder to controller dependency sets.
	dep_if deps ();

	dep_decoder u_dec
	(
		.insn (insn),
		.deps (deps.decoder)
	);

	cond_eval u_cond
	(
		.insn     (insn),
		.cpsr     (cpsr),
		.cond_met (cond_met)
	);

	issue_ctl u_ctl
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.flush     (flush),
		.inbubble  (inbubble),
		.insn      (insn),
		.inpc      (inpc),
		.deps      (deps.issue),
		.cond_met  (cond_met),
		.outstall  (outstall),
		.outbubble (outbubble),
		.outpc     (outpc),
		.outinsn   (outinsn)
	);

endmodule

// ==== verif/issue_stage_chk.sv ====
module issue_stage_chk
(
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic inbubble,
	input logic outstall,
	input logic outbubble,
	input arm_pkg::word_t outpc,
	input arm_pkg::word_t outinsn
);

	// First cycle out of reset carries a bubble.
	a_reset_bubble: assert property (@(posedge clk) $rose(rst_n) |-> outbubble)
		else $error("outbubble low in the first cycle after reset");

	// A stalled edge changes none of the stage registers.
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> ($stable(outbubble) && $stable(outpc) && $stable(outinsn)))
		else $error("stage outputs changed across a stalled edge");

	// Two bubbles issued on back to back unstalled edges leave execute and memory empty.
	a_no_false_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(!stall && !inbubble && outbubble && $past(outbubble) && !$past(stall))
		|-> !outstall)
		else $error("outstall high with an empty scoreboard");

endmodule

bind issue_stage issue_stage_chk chk
(
	.clk       (clk),
	.rst_n     (rst_n),
	.stall     (stall),
	.inbubble  (inbubble),
	.outstall  (outstall),
	.outbubble (outbubble),
	.outpc     (outpc),
	.outinsn   (outinsn)
);

// ==== verif/issue_stage_tb.sv ====
`include "arm_settings.svh"

module issue_stage_tb;

	localparam int drive_dly = 10;
	// The tests take about 700 cycles, and the limit is close to three times that.
	localparam int test_cycles = 700;
	localparam int max_cycles = 3 * test_cycles - 100;

	logic clk;
	logic rst_n;
	logic stall;
	logic flush;
	logic inbubble;
	arm_pkg::word_t insn;
	arm_pkg::word_t inpc;
	arm_pkg::word_t cpsr;
	logic outstall;
	logic outbubble;
	arm_pkg::word_t outpc;
	arm_pkg::word_t outinsn;

	int errors = 0;
	int cycles = 0;
	logic held;
	arm_pkg::word_t pc_next;

	// Reference model state, as it will be after the next rising edge.
	logic m_cpsr [`ISSUE_INFLIGHT];
	arm_pkg::reg_mask_t m_regs [`ISSUE_INFLIGHT];
	logic m_bubble;
	arm_pkg::word_t m_pc;
	arm_pkg::word_t m_insn;
	logic e_uc;
	arm_pkg::reg_mask_t e_ur;
	logic e_dc;
	arm_pkg::reg_mask_t e_dr;
	logic p_cpsr;
	arm_pkg::reg_mask_t p_regs;
	logic e_wait;
	logic e_kill;

	issue_stage dut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.flush     (flush),
		.inbubble  (inbubble),
		.insn      (insn),
		.inpc      (inpc),
		.cpsr      (cpsr),
		.outstall  (outstall),
		.outbubble (outbubble),
		.outpc     (outpc),
		.outinsn   (outinsn)
	);

	always #50 clk = ~clk;

	// ============================================================
	// Reference rules.
	// ============================================================
	function automatic arm_pkg::reg_mask_t rbit(input logic [3:0] r);
		arm_pkg::reg_mask_t m;
		m = '0;
		m[r] = 1'b1;
		m[`ARM_PC_IDX] = 1'b0;
		return m;
	endfunction

	// Odd codes are the inverse of the even one below them, and 1111 never runs.
	function automatic logic cond_pass(input logic [3:0] c, input arm_pkg::word_t f);
		logic n;
		logic z;
		logic cf;
		logic v;
		logic r;
		n = f[`CPSR_N];
		z = f[`CPSR_Z];
		cf = f[`CPSR_C];
		v = f[`CPSR_V];
		case (c[3:1])
			3'd0: r = z;
			3'd1: r = cf;
			3'd2: r = n;
			3'd3: r = v;
			3'd4: r = cf && !z;
			3'd5: r = (n == v);
			3'd6: r = !z && (n == v);
			default: r = 1'b1;
		endcase
		if (c[0])
			r = !r;
		return r;
	endfunction

	function automatic arm_pkg::insn_class_e classify(input arm_pkg::word_t i);
		if (i[27:22] == 6'b000000 && i[7:4] == 4'b1001)
			return arm_pkg::cls_multiply;
		if (i[27:23] == 5'b00010 && i[21:16] == 6'h0f && i[11:0] == 12'h000)
			return arm_pkg::cls_mrs;
		if (i[27:23] == 5'b00010 && i[21:4] == 18'h29f00)
			return arm_pkg::cls_msr;
		if (i[27:26] == 2'b00 && i[24:23] == 2'b10 && i[21:12] == 10'h28f)
			return arm_pkg::cls_msr_flags;
		if (i[27:23] == 5'b00010 && i[21:20] == 2'b00 && i[11:4] == 8'h09)
			return arm_pkg::cls_swap;
		if (i[27:4] == 24'h12fff1)
			return arm_pkg::cls_bx;
		if (i[27:25] == 3'b000 && !i[22] && i[11:7] == 5'b00001 && i[4])
			return arm_pkg::cls_half_reg;
		if (i[27:25] == 3'b000 && i[22] && i[7] && i[4])
			return arm_pkg::cls_half_imm;
		if (i[27:26] == 2'b00)
			return arm_pkg::cls_alu;
		if (i[27:25] == 3'b011 && i[4])
			return arm_pkg::cls_undefined;
		if (i[27:26] == 2'b01)
			return arm_pkg::cls_ldr_str;
		if (i[27:25] == 3'b100)
			return arm_pkg::cls_ldm_stm;
		if (i[27:25] == 3'b101)
			return arm_pkg::cls_branch;
		if (i[27:25] == 3'b110)
			return arm_pkg::cls_cop_xfer;
		if (i[27:24] == 4'b1110)
			return i[4] ? arm_pkg::cls_cop_reg : arm_pkg::cls_cop_data;
		return arm_pkg::cls_none;
	endfunction

	function automatic void ref_deps(input arm_pkg::word_t i, output logic uc,
		output arm_pkg::reg_mask_t ur, output logic dc, output arm_pkg::reg_mask_t dr);
		arm_pkg::reg_mask_t rn;
		arm_pkg::reg_mask_t rd;
		arm_pkg::reg_mask_t rs;
		arm_pkg::reg_mask_t rm;
		arm_pkg::reg_mask_t list;
		logic ld;
		rn = rbit(i[19:16]);
		rd = rbit(i[15:12]);
		rs = rbit(i[11:8]);
		rm = rbit(i[3:0]);
		list = i[15:0];
		list[`ARM_PC_IDX] = 1'b0;
		ld = i[20];
		uc = (i[31:28] != 4'he);
		ur = '0;
		dc = 1'b0;
		dr = '0;
		case (classify(i))
			arm_pkg::cls_multiply:
			begin
				ur = rm | rs | (i[21] ? rd : '0);
				dc = i[20];
				dr = rn;
			end
			arm_pkg::cls_mrs:
			begin
				uc = uc || !i[22];
				dr = rd;
			end
			arm_pkg::cls_msr:
			begin
				ur = rm;
				dc = 1'b1;
			end
			arm_pkg::cls_msr_flags:
			begin
				ur = i[25] ? '0 : rm;
				dc = 1'b1;
			end
			arm_pkg::cls_swap:
			begin
				ur = rn | rm;
				dr = rd;
			end
			arm_pkg::cls_bx:
				ur = rm;
			arm_pkg::cls_half_reg, arm_pkg::cls_half_imm, arm_pkg::cls_ldr_str:
			begin
				ur = rn | (ld ? '0 : rd);
				if (classify(i) == arm_pkg::cls_half_reg || (classify(i) == arm_pkg::cls_ldr_str && i[25]))
					ur = ur | rm;
				dr = ld ? rd : '0;
			end
			arm_pkg::cls_alu:
			begin
				// LSL and ROR by an immediate zero take the carry in.
				uc = uc || (!i[25] && !i[4] && i[11:7] == 5'd0 && i[6] == i[5]);
				ur = i[25] ? '0 : (rm | (i[4] ? rs : '0));
				if (!(i[24:23] == 2'b11 && i[21]))
					ur = ur | rn;
				dc = i[20];
				dr = (i[24:23] == 2'b10) ? '0 : rd;
			end
			arm_pkg::cls_ldm_stm:
			begin
				ur = rn | (ld ? '0 : list);
				dc = i[22];
				dr = (i[21] ? rn : '0) | (ld ? list : '0);
			end
			arm_pkg::cls_cop_xfer:
			begin
				ur = rn;
				dr = i[21] ? rn : '0;
			end
			arm_pkg::cls_cop_reg:
			begin
				ur = ld ? '0 : rd;
				dr = ld ? rd : '0;
			end
			arm_pkg::cls_branch, arm_pkg::cls_cop_data:
			begin
			end
			default:
				uc = 1'b0;
		endcase
	endfunction

	// ============================================================
	// Compare tasks.
	// ============================================================
	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input arm_pkg::word_t exp,
		input arm_pkg::word_t act);
		if (act !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// Outputs are stable at the falling edge; the model then steps to the next rising edge.
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < `ISSUE_INFLIGHT; k++)
			begin
				m_cpsr[k] = 1'b0;
				m_regs[k] = '0;
			end
			m_bubble = 1'b1;
			m_pc = '0;
			m_insn = '0;
		end
		else
		begin
			ref_deps(insn, e_uc, e_ur, e_dc, e_dr);
			p_cpsr = 1'b0;
			p_regs = '0;
			for (int k = 0; k < `ISSUE_INFLIGHT; k++)
			begin
				p_cpsr = p_cpsr | m_cpsr[k];
				p_regs = p_regs | m_regs[k];
			end
			e_wait = (e_uc && p_cpsr) || ((e_ur & p_regs) != '0);
			check_bit("outstall", stall || (e_wait && !inbubble), outstall);
			check_bit("outbubble", m_bubble, outbubble);
			check_word("outpc", m_pc, outpc);
			check_word("outinsn", m_insn, outinsn);
			if (!stall)
			begin
				e_kill = inbubble || e_wait || flush || !cond_pass(insn[31:28], cpsr);
				for (int k = `ISSUE_INFLIGHT - 1; k > 0; k--)
				begin
					m_cpsr[k] = m_cpsr[k-1];
					m_regs[k] = m_regs[k-1];
				end
				m_cpsr[0] = e_kill ? 1'b0 : e_dc;
				m_regs[0] = e_kill ? '0 : e_dr;
				m_bubble = e_kill;
				m_pc = inpc;
				m_insn = insn;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// ============================================================
	// Stimulus tasks.
	// ============================================================
	// Present one instruction and count the cycles it waits before issue.
	task automatic issue(input arm_pkg::word_t i, input arm_pkg::word_t flags, input logic fl,
		input int exp_stalls);
		int n;
		n = 0;
		@(posedge clk);
		#drive_dly;
		insn = i;
		inpc = pc_next;
		cpsr = flags;
		inbubble = 1'b0;
		stall = 1'b0;
		flush = fl;
		pc_next = pc_next + 32'd4;
		@(negedge clk);
		while (outstall && n < 8)
		begin
			n++;
			@(negedge clk);
		end
		check_word("stall_cycles", arm_pkg::word_t'(exp_stalls), arm_pkg::word_t'(n));
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#drive_dly;
			inbubble = 1'b1;
			stall = 1'b0;
			flush = 1'b0;
		end
	endtask

	task automatic pair(input arm_pkg::word_t prod, input arm_pkg::word_t cons,
		input arm_pkg::word_t flags, input int exp_stalls);
		idle(2);
		issue(prod, flags, 1'b0, 0);
		issue(cons, flags, 1'b0, exp_stalls);
	endtask

	// Hold stall high for n cycles with the last issued instruction on the outputs.
	task automatic hold_outputs(input int n, input arm_pkg::word_t exp_insn);
		arm_pkg::word_t pc;
		pc = pc_next - 32'd4;
		@(posedge clk);
		#drive_dly;
		stall = 1'b1;
		inbubble = 1'b0;
		insn = $urandom;
		repeat (n)
		begin
			@(negedge clk);
			check_bit("outbubble", 1'b0, outbubble);
			check_word("outpc", pc, outpc);
			check_word("outinsn", exp_insn, outinsn);
			@(posedge clk);
			#drive_dly;
			insn = $urandom;
		end
	endtask

	// Mostly always-executed, registers squeezed toward r0..r3 for hazards.
	function automatic arm_pkg::word_t rand_insn();
		arm_pkg::word_t i;
		i = $urandom;
		if ($urandom_range(1) == 0)
			i[31:28] = 4'he;
		if ($urandom_range(2) != 0)
		begin
			i[19:18] = 2'b00;
			i[15:14] = 2'b00;
			i[11:10] = 2'b00;
			i[3:2] = 2'b00;
		end
		if ($urandom_range(1) == 0)
			i[27:26] = 2'b00;
		return i;
	endfunction

	// ============================================================
	// Test sequence.
	// ============================================================
	initial
	begin
		void'($urandom(32'h3b59));
		clk = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		inbubble = 1'b1;
		insn = '0;
		inpc = '0;
		cpsr = '0;
		pc_next = 32'h100;
		repeat (5) @(posedge clk);
		#drive_dly;
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("outbubble", 1'b1, outbubble);
		check_bit("outstall", 1'b0, outstall);

		// Branches under every condition code.
		for (int c = 0; c < 32; c++)
			issue({4'(c), 4'b1010, 24'($urandom)},
				arm_pkg::word_t'($urandom_range(15)) << 28, 1'b0, 0);

		// Register hazards through Rn, Rm and Rs.
		pair(32'he0813002, 32'he0834005, '0, 2);
		pair(32'he0813002, 32'he0814003, '0, 2);
		pair(32'he0813002, 32'he0814312, '0, 2);
		pair(32'he0813002, 32'he1a0400f, '0, 0);
		pair(32'he1a0f001, 32'he08f4001, '0, 0);
		// ADDEQ with Z clear writes nothing.
		pair(32'h00813002, 32'he0834005, '0, 0);

		// CPSR hazards.
		pair(32'he0913002, 32'h01a04005, '0, 2);
		pair(32'he0913002, 32'he10f0000, '0, 2);
		pair(32'he0913002, 32'he1a04005, '0, 2);
		pair(32'he0913002, 32'he1a04085, '0, 0);

		// External stall, then flush.
		idle(2);
		issue(32'he0813002, '0, 1'b0, 0);
		hold_outputs(3, 32'he0813002);
		issue(32'he0834005, '0, 1'b0, 2);
		idle(2);
		issue(32'he0813002, '0, 1'b1, 0);
		issue(32'he0834005, '0, 1'b0, 0);

		// Random stream, holding the instruction while the stage stalls.
		for (int k = 0; k < 500; k++)
		begin
			@(negedge clk);
			held = outstall;
			@(posedge clk);
			#drive_dly;
			stall = ($urandom_range(9) == 0);
			flush = ($urandom_range(19) == 0);
			cpsr = arm_pkg::word_t'($urandom_range(15)) << 28;
			if (!held)
			begin
				insn = rand_insn();
				inpc = pc_next;
				pc_next = pc_next + 32'd4;
				inbubble = ($urandom_range(4) == 0);
			end
		end
		idle(3);
		@(negedge clk);

		$display("Run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/arm_pkg.sv
hdl/dep_if.sv
hdl/dep_decoder.sv
hdl/cond_eval.sv
hdl/issue_ctl.sv
hdl/issue_stage.sv
verif/issue_stage_chk.sv
verif/issue_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module issue_stage_tb -o issue_stage_sim

./obj_dir/issue_stage_sim 2>&1 | tee sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
